/* hw/ppu_reg_pkg.sv */
package ppu_reg_pkg;

  // ==============================
  // CPU bus address map
  // ==============================

  // Video memory window
  localparam logic [15:0] vram_start = 16'h8000;
  localparam logic [15:0] vram_end   = 16'h9FFF;

  // Sprite attribute window, stored only
  localparam logic [15:0] oam_start = 16'hFE00;
  localparam logic [15:0] oam_end   = 16'hFE9F;

  // Display registers
  localparam logic [15:0] reg_lcdc = 16'hFF40;
  localparam logic [15:0] reg_scy  = 16'hFF42;
  localparam logic [15:0] reg_scx  = 16'hFF43;
  localparam logic [15:0] reg_ly   = 16'hFF44;
  localparam logic [15:0] reg_lyc  = 16'hFF45;
  localparam logic [15:0] reg_bgp  = 16'hFF47;

  // Background map is fixed at the low map
  localparam logic [15:0] tile_map_base = 16'h9800;

  // LY is kept in the mode timer
  typedef struct packed {
    logic [7:0] lcdc;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    logic [7:0] bgp;
  } ppu_regs_t;

  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        write_en;
    logic        read_en;
  } bus_req_t;

endpackage

/* hw/ppu_pix_pkg.sv */
package ppu_pix_pkg;

  // ==============================
  // Scanline timing
  // ==============================
  localparam logic [8:0] dots_per_line   = 9'd456;
  localparam logic [7:0] lines_per_frame = 8'd154;
  localparam logic [7:0] visible_lines   = 8'd144;

  // Last dot of OAM scan and of drawing
  localparam logic [8:0] mode2_end = 9'd80;
  localparam logic [8:0] mode3_end = 9'd252;

  localparam logic [7:0] screen_width = 8'd160;

  // Background FIFO entries
  localparam int fifo_depth = 16;

  typedef enum logic [1:0] {
    mode_hblank = 2'd0,
    mode_vblank = 2'd1,
    mode_oam    = 2'd2,
    mode_draw   = 2'd3
  } ppu_mode_t;

  // ==============================
  // Pixel types
  // ==============================

  // Slot 7 holds the leftmost pixel
  typedef logic [7:0][1:0] pixel_row_t;

  typedef struct packed {
    logic [7:0] x;
    logic [7:0] y;
    logic [1:0] shade;
  } screen_pixel_t;

endpackage

/* hw/ppu_mode_timer.sv */
module ppu_mode_timer (
  input  logic                   clk,
  input  logic                   reset,
  output ppu_pix_pkg::ppu_mode_t mode,
  output logic [7:0]             ly,
  output logic                   line_start
);
  import ppu_pix_pkg::*;

  logic [8:0] dot;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode       <= mode_oam;
      ly         <= 8'd0;
      dot        <= 9'd0;
      line_start <= 1'b0;
    end else begin
      // Pulse lines up with the first drawing dot
      line_start <= (mode == mode_oam) && (dot == mode2_end);

      if (dot == dots_per_line - 9'd1) begin
        dot <= 9'd0;
      end else begin
        dot <= dot + 9'd1;
      end

      unique case (mode)
        mode_oam:  if (dot == mode2_end) mode <= mode_draw;
        mode_draw: if (dot == mode3_end) mode <= mode_hblank;
        mode_hblank, mode_vblank: begin
          if (dot == dots_per_line - 9'd1) begin
            if (ly == lines_per_frame - 8'd1) begin
              ly   <= 8'd0;
              mode <= mode_oam;
            end else begin
              ly <= ly + 8'd1;
              // Past the last visible line the whole line is vblank
              mode <= (ly >= visible_lines - 8'd1) ? mode_vblank : mode_oam;
            end
          end
        end
      endcase
    end
  end

endmodule

/* hw/ppu_mem_regs.sv */
module ppu_mem_regs (
  input  logic                   clk,
  input  logic                   reset,
  input  ppu_reg_pkg::bus_req_t  bus,
  output logic [7:0]             rdata,
  input  ppu_pix_pkg::ppu_mode_t mode,
  input  logic [7:0]             ly,
  output ppu_reg_pkg::ppu_regs_t regs,
  input  logic [15:0]            fetch_addr,
  output logic [7:0]             fetch_data
);
  import ppu_reg_pkg::*;
  import ppu_pix_pkg::*;

  // Indexed directly by bus address
  logic [7:0] vram [vram_start:vram_end];
  logic [7:0] oam  [oam_start:oam_end];

  logic in_vram;
  logic in_oam;
  logic vram_open;
  logic oam_open;

  assign in_vram = bus.addr inside {[vram_start:vram_end]};
  assign in_oam  = bus.addr inside {[oam_start:oam_end]};

  // CPU loses VRAM while drawing, OAM during scan and drawing
  assign vram_open = (mode != mode_draw);
  assign oam_open  = (mode != mode_draw) && (mode != mode_oam);

  // ==============================
  // CPU writes
  // ==============================
  always_ff @(posedge clk) begin
    if (bus.write_en && in_vram && vram_open) begin
      vram[bus.addr] <= bus.wdata;
    end
    if (bus.write_en && in_oam && oam_open) begin
      oam[bus.addr] <= bus.wdata;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs <= '0;
    end else if (bus.write_en) begin
      case (bus.addr)
        reg_lcdc: regs.lcdc <= bus.wdata;
        reg_scy:  regs.scy  <= bus.wdata;
        reg_scx:  regs.scx  <= bus.wdata;
        reg_lyc:  regs.lyc  <= bus.wdata;
        reg_bgp:  regs.bgp  <= bus.wdata;
        // LY and unmapped addresses fall through
        default:  ;
      endcase
    end
  end

  // ==============================
  // CPU reads
  // ==============================
  always_comb begin
    rdata = 8'hFF;
    if (bus.read_en) begin
      if (in_vram) begin
        if (vram_open) rdata = vram[bus.addr];
      end else if (in_oam) begin
        if (oam_open) rdata = oam[bus.addr];
      end else begin
        case (bus.addr)
          reg_lcdc: rdata = regs.lcdc;
          reg_scy:  rdata = regs.scy;
          reg_scx:  rdata = regs.scx;
          reg_ly:   rdata = ly;
          reg_lyc:  rdata = regs.lyc;
          reg_bgp:  rdata = regs.bgp;
          default:  rdata = 8'hFF;
        endcase
      end
    end
  end

  // Fetcher port, always inside video memory
  assign fetch_data = vram[fetch_addr];

endmodule

/* hw/ppu_bg_fetcher.sv */
module ppu_bg_fetcher (
  input  logic                    clk,
  input  logic                    reset,
  input  ppu_reg_pkg::ppu_regs_t  regs,
  input  logic [7:0]              ly,
  input  logic                    line_start,
  output logic [15:0]             fetch_addr,
  input  logic [7:0]              fetch_data,
  input  logic                    room_for_row,
  output logic                    push,
  output ppu_pix_pkg::pixel_row_t push_row
);
  import ppu_reg_pkg::*;

  typedef enum logic [1:0] {st_map, st_low, st_high, st_push} fetch_state_t;

  fetch_state_t state;
  fetch_state_t fetch_sel;
  logic [4:0]   col;
  logic [4:0]   cur_col;
  logic [4:0]   map_col;
  logic [7:0]   bg_row;
  logic [7:0]   tile_num;
  logic [7:0]   low_byte;
  logic [7:0]   high_byte;

  // line_start doubles as the map read of column zero
  assign fetch_sel = line_start ? st_map : state;
  assign cur_col   = line_start ? 5'd0 : col;
  assign bg_row    = regs.scy + ly;
  assign map_col   = regs.scx[7:3] + cur_col;

  always_comb begin
    case (fetch_sel)
      st_map:  fetch_addr = tile_map_base + {6'd0, bg_row[7:3], map_col};
      st_low:  fetch_addr = vram_start + {4'd0, tile_num, bg_row[2:0], 1'b0};
      st_high: fetch_addr = vram_start + {4'd0, tile_num, bg_row[2:0], 1'b1};
      default: fetch_addr = vram_start;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= st_map;
      col   <= 5'd0;
    end else if (line_start) begin
      state <= st_low;
      col   <= 5'd0;
    end else begin
      unique case (state)
        st_map:  state <= st_low;
        st_low:  state <= st_high;
        st_high: state <= st_push;
        st_push: begin
          // Hold the row until the FIFO can take all eight
          if (room_for_row) begin
            state <= st_map;
            col   <= col + 5'd1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_sel == st_map) tile_num <= fetch_data;
    if (state == st_low) low_byte <= fetch_data;
    if (state == st_high) high_byte <= fetch_data;
  end

  assign push = (state == st_push) && room_for_row;

  // Color index is high bit over low bit, MSB is leftmost
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      push_row[i] = {high_byte[i], low_byte[i]};
    end
  end

endmodule

/* hw/ppu_pixel_fifo.sv */
module ppu_pixel_fifo (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    flush,
  input  logic                    push,
  input  ppu_pix_pkg::pixel_row_t push_row,
  input  logic                    pop,
  output logic [1:0]              top_pixel,
  output logic                    empty,
  output logic                    room_for_row
);
  import ppu_pix_pkg::*;

  typedef logic [$clog2(fifo_depth)-1:0] ptr_t;
  typedef logic [$clog2(fifo_depth):0]   count_t;

  logic [1:0] mem [fifo_depth];
  ptr_t       rd_ptr;
  ptr_t       wr_ptr;
  count_t     count;
  count_t     count_next;

  always_comb begin
    count_next = count;
    if (push) count_next = count_next + count_t'($size(push_row));
    if (pop) count_next = count_next - count_t'(1);
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      // New line, stale pixels dropped
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + ptr_t'($size(push_row));
      if (pop) rd_ptr <= rd_ptr + ptr_t'(1);
      count <= count_next;
    end
  end

  // Whole row lands in one cycle, leftmost first
  always_ff @(posedge clk) begin
    if (push) begin
      for (int i = 0; i < $size(push_row); i++) begin
        mem[wr_ptr + ptr_t'(i)] <= push_row[$size(push_row) - 1 - i];
      end
    end
  end

  assign top_pixel    = mem[rd_ptr];
  assign empty        = (count == '0);
  assign room_for_row = (count <= count_t'(fifo_depth - $size(push_row)));

endmodule

/* hw/ppu_pixel_output.sv */
module ppu_pixel_output (
  input  logic                       clk,
  input  logic                       reset,
  input  ppu_pix_pkg::ppu_mode_t     mode,
  input  logic [7:0]                 ly,
  input  logic                       line_start,
  input  logic [2:0]                 scx_fine,
  input  logic [7:0]                 bgp,
  input  logic                       empty,
  input  logic [1:0]                 top_pixel,
  output logic                       pop,
  output ppu_pix_pkg::screen_pixel_t pixel,
  output logic                       pixel_valid
);
  import ppu_pix_pkg::*;

  logic [2:0] drop;
  logic [7:0] x;

  // FIFO still holds last line's pixels during line_start
  assign pop = (mode == mode_draw) && !line_start && !empty && (x != screen_width);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      drop        <= 3'd0;
      x           <= 8'd0;
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= pop && (drop == 3'd0);
      if (line_start) begin
        drop <= scx_fine;
        x    <= 8'd0;
      end else if (pop) begin
        // Fine scroll pixels are popped and thrown away
        if (drop != 3'd0) begin
          drop <= drop - 3'd1;
        end else begin
          x <= x + 8'd1;
        end
      end
    end
  end

  // Palette holds two bits per color index
  always_ff @(posedge clk) begin
    if (pop) begin
      pixel.x     <= x;
      pixel.y     <= ly;
      pixel.shade <= bgp[{top_pixel, 1'b0} +: 2];
    end
  end

endmodule

/* hw/ppu.sv */
module ppu (
  input  logic                       clk,
  input  logic                       reset,
  input  ppu_reg_pkg::bus_req_t      bus,
  output logic [7:0]                 rdata,
  output ppu_pix_pkg::ppu_mode_t     mode,
  output ppu_pix_pkg::screen_pixel_t pixel,
  output logic                       pixel_valid
);
  import ppu_reg_pkg::*;
  import ppu_pix_pkg::*;

  logic [7:0]  ly;
  logic        line_start;
  ppu_regs_t   regs;
  logic [15:0] fetch_addr;
  logic [7:0]  fetch_data;
  logic        room_for_row;
  logic        push;
  pixel_row_t  push_row;
  logic        pop;
  logic [1:0]  top_pixel;
  logic        empty;

  // ==============================
  // Timing and CPU side
  // ==============================
  ppu_mode_timer u_timer (
    .clk        (clk),
    .reset      (reset),
    .mode       (mode),
    .ly         (ly),
    .line_start (line_start)
  );

  ppu_mem_regs u_mem (
    .clk        (clk),
    .reset      (reset),
    .bus        (bus),
    .rdata      (rdata),
    .mode       (mode),
    .ly         (ly),
    .regs       (regs),
    .fetch_addr (fetch_addr),
    .fetch_data (fetch_data)
  );

  // ==============================
  // Background pixel pipeline
  // ==============================
  ppu_bg_fetcher u_fetcher (
    .clk          (clk),
    .reset        (reset),
    .regs         (regs),
    .ly           (ly),
    .line_start   (line_start),
    .fetch_addr   (fetch_addr),
    .fetch_data   (fetch_data),
    .room_for_row (room_for_row),
    .push         (push),
    .push_row     (push_row)
  );

  ppu_pixel_fifo u_fifo (
    .clk          (clk),
    .reset        (reset),
    .flush        (line_start),
    .push         (push),
    .push_row     (push_row),
    .pop          (pop),
    .top_pixel    (top_pixel),
    .empty        (empty),
    .room_for_row (room_for_row)
  );

  ppu_pixel_output u_out (
    .clk         (clk),
    .reset       (reset),
    .mode        (mode),
    .ly          (ly),
    .line_start  (line_start),
    .scx_fine    (regs.scx[2:0]),
    .bgp         (regs.bgp),
    .empty       (empty),
    .top_pixel   (top_pixel),
    .pop         (pop),
    .pixel       (pixel),
    .pixel_valid (pixel_valid)
  );

endmodule

/* test/ppu_clock_gen.sv */
module ppu_clock_gen #(
  parameter int period       = 100,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // Release lands on a rising edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

/* test/ppu_checker.sv */
module ppu_checker (
  input logic                   clk,
  input logic                   reset,
  input ppu_pix_pkg::ppu_mode_t mode,
  input logic [7:0]             ly,
  input logic                   pixel_valid
);
  import ppu_pix_pkg::*;

  int fail_count = 0;

  // Screen pixels only leave the pipeline while drawing
  pixel_in_draw: assert property (
    @(posedge clk) disable iff (reset) pixel_valid |-> (mode == mode_draw)
  ) else begin
    $error("pixel_valid high outside mode_draw");
    fail_count++;
  end

  // A new frame always starts with the OAM scan
  no_draw_after_vblank: assert property (
    @(posedge clk) disable iff (reset) (mode == mode_vblank) |=> (mode != mode_draw)
  ) else begin
    $error("mode_draw directly after mode_vblank");
    fail_count++;
  end

  ly_in_range: assert property (
    @(posedge clk) disable iff (reset) ly < lines_per_frame
  ) else begin
    $error("ly reached %0d", ly);
    fail_count++;
  end

endmodule

/* test/ppu_tb.sv */
module ppu_tb;
  import ppu_reg_pkg::*;
  import ppu_pix_pkg::*;

  localparam int clk_period = 100;
  localparam longint frame_cycles = longint'(dots_per_line) * longint'(lines_per_frame);

  // Ten whole lines of vblank per frame
  localparam int vblank_len = 10 * int'(dots_per_line);

  // Background used for the pixel test
  localparam logic [7:0] scx_val = 8'hE5;
  localparam logic [7:0] scy_val = 8'h0F;
  localparam logic [7:0] bgp_val = 8'h1B;
  localparam int tile_count = 32;

  typedef struct {
    string       name;
    ppu_mode_t   mode;
    logic [15:0] addr;
    logic [7:0]  data;
    bit          is_write;
    logic [7:0]  expected;
    bit          from_ly;
  } access_t;

  logic          clk;
  logic          reset;
  bus_req_t      bus;
  logic [7:0]    rdata;
  ppu_mode_t     mode;
  screen_pixel_t pixel;
  logic          pixel_valid;

  access_t    accesses[$];
  bit         table_ready = 1'b0;
  int         draw_count = 0;
  int         vblank_cycles = 0;
  ppu_mode_t  last_mode = mode_oam;
  logic [31:0] rng = 32'h2b95;
  logic [7:0] vram_model [0:8191];

  ppu_clock_gen #(.period(clk_period), .reset_cycles(8)) u_clock (
    .clk   (clk),
    .reset (reset)
  );

  ppu u_dut (
    .clk         (clk),
    .reset       (reset),
    .bus         (bus),
    .rdata       (rdata),
    .mode        (mode),
    .pixel       (pixel),
    .pixel_valid (pixel_valid)
  );

  bind ppu ppu_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .mode        (mode),
    .ly          (ly),
    .pixel_valid (pixel_valid)
  );

  // ==============================
  // Reference models
  // ==============================
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Line index from drawing periods with ten vblank lines per 144 visible
  function automatic logic [7:0] expected_ly(input ppu_mode_t m, input int draws);
    int past;
    int line;
    past = (m == mode_oam) ? draws : draws - 1;
    line = past + (int'(lines_per_frame) - int'(visible_lines)) * (past / int'(visible_lines));
    if (m == mode_vblank) line = line + 1;
    return 8'(line % int'(lines_per_frame));
  endfunction

  function automatic logic [1:0] model_shade(input int line, input int x);
    int bg_row;
    int s;
    int col;
    int base;
    logic [7:0] tile;
    logic [7:0] lo;
    logic [7:0] hi;
    logic [1:0] color;
    bg_row = (int'(scy_val) + line) % 256;
    s = x + int'(scx_val) % 8;
    col = (int'(scx_val) / 8 + s / 8) % 32;
    tile = vram_model[int'(tile_map_base - vram_start) + (bg_row / 8) * 32 + col];
    base = int'(tile) * 16 + (bg_row % 8) * 2;
    lo = vram_model[base];
    hi = vram_model[base + 1];
    color = {hi[7 - s % 8], lo[7 - s % 8]};
    return 2'(bgp_val >> (2 * color));
  endfunction

  // ==============================
  // Helpers
  // ==============================
  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    assert (actual === expected) else begin
      $display("** Error %s: expected %02h, actual %02h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  // Returns at the first cycle of a fresh period of the target mode
  task automatic wait_for_mode(input ppu_mode_t target);
    ppu_mode_t prev;
    @(negedge clk);
    prev = mode;
    @(negedge clk);
    while (!(mode == target && prev != target)) begin
      prev = mode;
      @(negedge clk);
    end
  endtask

  task automatic write_byte(input logic [15:0] addr, input logic [7:0] data);
    @(posedge clk);
    bus.addr     <= addr;
    bus.wdata    <= data;
    bus.write_en <= 1'b1;
    bus.read_en  <= 1'b0;
  endtask

  task automatic apply_access(input access_t a);
    logic [7:0] actual;
    logic [7:0] expected;
    wait_for_mode(a.mode);
    @(posedge clk);
    bus.addr     <= a.addr;
    bus.wdata    <= a.data;
    bus.write_en <= a.is_write;
    bus.read_en  <= !a.is_write;
    @(negedge clk);
    actual = rdata;
    expected = a.from_ly ? expected_ly(a.mode, draw_count) : a.expected;
    @(posedge clk);
    bus.write_en <= 1'b0;
    bus.read_en  <= 1'b0;
    if (!a.is_write) check_value(a.name, expected, actual);
  endtask

  function automatic void add_entry(input string name, input ppu_mode_t m,
                                    input logic [15:0] addr, input logic [7:0] data,
                                    input bit is_write, input logic [7:0] expected,
                                    input bit from_ly);
    accesses.push_back('{name, m, addr, data, is_write, expected, from_ly});
  endfunction

  function automatic void fill_table();
    add_entry("lcdc_wr", mode_hblank, reg_lcdc, 8'h91, 1'b1, 8'h00, 1'b0);
    add_entry("lcdc_rd", mode_hblank, reg_lcdc, 8'h00, 1'b0, 8'h91, 1'b0);
    add_entry("scy_wr", mode_hblank, reg_scy, 8'h3C, 1'b1, 8'h00, 1'b0);
    add_entry("scy_rd", mode_oam, reg_scy, 8'h00, 1'b0, 8'h3C, 1'b0);
    add_entry("scx_wr", mode_hblank, reg_scx, 8'hA7, 1'b1, 8'h00, 1'b0);
    add_entry("scx_rd", mode_draw, reg_scx, 8'h00, 1'b0, 8'hA7, 1'b0);
    add_entry("lyc_wr", mode_hblank, reg_lyc, 8'h2E, 1'b1, 8'h00, 1'b0);
    add_entry("lyc_rd", mode_hblank, reg_lyc, 8'h00, 1'b0, 8'h2E, 1'b0);
    add_entry("bgp_wr", mode_hblank, reg_bgp, 8'hE4, 1'b1, 8'h00, 1'b0);
    add_entry("bgp_rd", mode_hblank, reg_bgp, 8'h00, 1'b0, 8'hE4, 1'b0);
    add_entry("ly_wr", mode_hblank, reg_ly, 8'h55, 1'b1, 8'h00, 1'b0);
    add_entry("ly_rd_after_wr", mode_oam, reg_ly, 8'h00, 1'b0, 8'h00, 1'b1);
    add_entry("unmapped_ff41", mode_hblank, 16'hFF41, 8'h00, 1'b0, 8'hFF, 1'b0);
    add_entry("unmapped_ff46", mode_hblank, 16'hFF46, 8'h00, 1'b0, 8'hFF, 1'b0);
    add_entry("unmapped_a000", mode_hblank, 16'hA000, 8'h00, 1'b0, 8'hFF, 1'b0);
    add_entry("vram_wr_hblank", mode_hblank, 16'h8123, 8'h5A, 1'b1, 8'h00, 1'b0);
    add_entry("vram_rd_hblank", mode_hblank, 16'h8123, 8'h00, 1'b0, 8'h5A, 1'b0);
    add_entry("vram_wr_draw", mode_draw, 16'h8123, 8'hC3, 1'b1, 8'h00, 1'b0);
    add_entry("vram_rd_draw", mode_draw, 16'h8123, 8'h00, 1'b0, 8'hFF, 1'b0);
    add_entry("vram_rd_kept", mode_oam, 16'h8123, 8'h00, 1'b0, 8'h5A, 1'b0);
    add_entry("oam_wr_hblank", mode_hblank, 16'hFE10, 8'h77, 1'b1, 8'h00, 1'b0);
    add_entry("oam_rd_hblank", mode_hblank, 16'hFE10, 8'h00, 1'b0, 8'h77, 1'b0);
    add_entry("oam_wr_scan", mode_oam, 16'hFE10, 8'h11, 1'b1, 8'h00, 1'b0);
    add_entry("oam_rd_scan", mode_oam, 16'hFE10, 8'h00, 1'b0, 8'hFF, 1'b0);
    add_entry("oam_wr_draw", mode_draw, 16'hFE10, 8'h22, 1'b1, 8'h00, 1'b0);
    add_entry("oam_rd_draw", mode_draw, 16'hFE10, 8'h00, 1'b0, 8'hFF, 1'b0);
    add_entry("oam_rd_kept", mode_hblank, 16'hFE10, 8'h00, 1'b0, 8'h77, 1'b0);
    add_entry("ly_rd_draw", mode_draw, reg_ly, 8'h00, 1'b0, 8'h00, 1'b1);
    add_entry("ly_rd_hblank", mode_hblank, reg_ly, 8'h00, 1'b0, 8'h00, 1'b1);
    add_entry("ly_rd_vblank", mode_vblank, reg_ly, 8'h00, 1'b0, 8'h00, 1'b1);
    add_entry("ly_rd_wrap", mode_oam, reg_ly, 8'h00, 1'b0, 8'h00, 1'b1);
  endfunction

  // Scroll, palette, random tile data and map in one vblank
  task automatic load_background();
    logic [15:0] addr;
    logic [7:0]  tile;
    wait_for_mode(mode_vblank);
    write_byte(reg_scx, scx_val);
    write_byte(reg_scy, scy_val);
    write_byte(reg_bgp, bgp_val);
    for (int i = 0; i < tile_count * 16; i++) begin
      rng = xorshift(rng);
      vram_model[i] = rng[7:0];
      write_byte(vram_start + 16'(i), rng[7:0]);
    end
    for (int line = 0; line < 2; line++) begin
      for (int col = 0; col < 32; col++) begin
        addr = tile_map_base + 16'(((int'(scy_val) + line) / 8) * 32 + col);
        rng = xorshift(rng);
        tile = 8'(rng[7:0] % tile_count);
        vram_model[addr - vram_start] = tile;
        write_byte(addr, tile);
      end
    end
    @(posedge clk);
    bus.write_en <= 1'b0;
  endtask

  task automatic capture_line(input int line);
    int    count;
    string tag;
    wait_for_mode(mode_draw);
    count = 0;
    while (mode == mode_draw) begin
      if (pixel_valid) begin
        tag = $sformatf("line%0d_px%0d", line, count);
        check_value({tag, "_x"}, 8'(count), pixel.x);
        check_value({tag, "_y"}, 8'(line), pixel.y);
        check_value({tag, "_shade"}, {6'd0, model_shade(line, count)}, {6'd0, pixel.shade});
        count++;
      end
      @(negedge clk);
    end
    check_value($sformatf("line%0d_pixel_count", line), screen_width, 8'(count));
  endtask

  // ==============================
  // Processes
  // ==============================

  // Drawing periods and vblank length from the mode seen before each edge
  always @(posedge clk) begin
    if (!reset && mode == mode_draw && last_mode != mode_draw) draw_count++;
    if (!reset && mode == mode_vblank) begin
      vblank_cycles++;
    end else if (vblank_cycles != 0) begin
      assert (vblank_cycles == vblank_len) else begin
        $display("** Error vblank_length: expected %0d, actual %0d",
                 vblank_len, vblank_cycles);
        stop_with_failure();
      end
      vblank_cycles = 0;
    end
    last_mode = mode;
  end

  initial begin
    longint limit;
    wait (table_ready);
    limit = (3 * frame_cycles + longint'(accesses.size()) * dots_per_line) * clk_period;
    #(limit);
    $display("Watchdog expired before the tests finished");
    stop_with_failure();
  end

  initial begin
    wait (u_dut.u_checker.fail_count != 0);
    $display("A bound assertion on the mode or pixel rules failed");
    stop_with_failure();
  end

  initial begin
    bus.addr     <= '0;
    bus.wdata    <= '0;
    bus.write_en <= 1'b0;
    bus.read_en  <= 1'b0;
    fill_table();
    table_ready = 1'b1;
    @(negedge reset);
    foreach (accesses[i]) apply_access(accesses[i]);
    load_background();
    capture_line(0);
    capture_line(1);
    if (u_dut.u_checker.fail_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

endmodule

/* ppu.f */
hw/ppu_reg_pkg.sv
hw/ppu_pix_pkg.sv
hw/ppu_mode_timer.sv
hw/ppu_mem_regs.sv
hw/ppu_bg_fetcher.sv
hw/ppu_pixel_fifo.sv
hw/ppu_pixel_output.sv
hw/ppu.sv
test/ppu_clock_gen.sv
test/ppu_checker.sv
test/ppu_tb.sv
